/* design/sparseMac_params.svh */
// ======================================
// Build-time sizes of the sparse MAC unit
// Operand width, channel and weight depths
// and the address and sum widths derived
// from them
// ======================================
`ifndef SPARSEMAC_PARAMS_SVH
`define SPARSEMAC_PARAMS_SVH

// Unsigned operand width
`define DATA_WIDTH 8

// Channels scanned per job
`define CHANNEL_DEPTH 16

// Weight block shape
`define BLOCK_DEPTH 2
`define KERNEL_SIZE 9
`define WEI_SLOTS (`BLOCK_DEPTH * `KERNEL_SIZE)

// Compressed address widths
`define CH_ADDR_W $clog2(`CHANNEL_DEPTH)
`define WEI_ADDR_W $clog2(`WEI_SLOTS)

// Sum width, room for three channel-deep sums
`define ACC_WIDTH (`DATA_WIDTH + $clog2(3 * `CHANNEL_DEPTH))

`endif

/* design/sparseDataPkg.sv */
// ======================================
// Data-side types of the sparse MAC unit
// Operand and sum words, flag masks,
// compressed addresses, operand bundle
// ======================================
`include "sparseMac_params.svh"

package sparseDataPkg;

    // Unsigned operand words
    typedef logic [`DATA_WIDTH-1:0] actWord;
    typedef logic [`DATA_WIDTH-1:0] weiWord;

    // Wrapping partial sum
    typedef logic [`ACC_WIDTH-1:0] accWord;

    // One nonzero flag per channel
    typedef logic [`CHANNEL_DEPTH-1:0] flagVec;

    // Compressed activation address and scan offsets
    typedef logic [`CH_ADDR_W-1:0] chAddr;

    // Slot index into the weight block
    typedef logic [`WEI_ADDR_W-1:0] weiAddr;

    // Everything the datapath reads for one job
    // Held stable by the source from start to done
    typedef struct packed {
        actWord [`CHANNEL_DEPTH-1:0] actVec;
        weiWord [`WEI_SLOTS-1:0]     weiBlk;
        weiAddr                      weiBase;
    } macOperands;

endpackage

/* design/sparseCtrlPkg.sv */
// ======================================
// Control-side types of the sparse MAC
// State encoding of the control FSM and
// the per-cycle scan step
// ======================================

package sparseCtrlPkg;

    // Control FSM states
    // IDLE waits for start, COMP scans and accumulates
    typedef enum logic {
        IDLE = 1'b0,
        COMP = 1'b1
    } macState;

    // One scan step of the flag scanner
    // Offsets count the set flags passed in each mask
    typedef struct packed {
        logic                 valid;
        sparseDataPkg::chAddr offsetAct;
        sparseDataPkg::chAddr offsetWei;
    } scanStep;

endpackage

/* design/flagScanner.sv */
// ======================================
// Flag scanner
// Remaining activation and weight masks,
// lowest common channel, address offsets
// and the clear mask for passed flags
// ======================================
`include "sparseMac_params.svh"

module flagScanner (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  sparseDataPkg::flagVec  flagAct,
    input  sparseDataPkg::flagVec  flagWei,
    input  logic                   scanEn,
    output sparseCtrlPkg::scanStep step,
    output logic                   pairsLeft
);
    import sparseDataPkg::*;
    import sparseCtrlPkg::*;

    // One bit wider than chAddr so a full mask is countable
    typedef logic [`CH_ADDR_W:0] flagCount;

    flagVec   remAct;
    flagVec   remWei;
    flagVec   commonMask;
    flagVec   lowBit;
    flagVec   passMask;
    flagCount actCount;
    flagCount weiCount;

    // ======================================
    // Remaining masks
    // ======================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remAct <= '0;
            remWei <= '0;
        end else if (start) begin
            // New job, also when a scan is still running
            remAct <= flagAct;
            remWei <= flagWei;
        end else if (step.valid) begin
            // Drop everything up to and including the pair
            remAct <= remAct & ~passMask;
            remWei <= remWei & ~passMask;
        end
    end

    // ======================================
    // Next common channel
    // ======================================
    assign commonMask = remAct & remWei;
    assign pairsLeft  = |commonMask;

    // Isolate lowest set bit, then fill everything below it
    assign lowBit   = commonMask & (~commonMask + flagVec'(1));
    assign passMask = lowBit | (lowBit - flagVec'(1));

    // Set flags at or below the pair channel, per mask
    always_comb begin
        actCount = '0;
        weiCount = '0;
        for (int i = 0; i < `CHANNEL_DEPTH; i++) begin
            actCount = actCount + flagCount'(remAct[i] & passMask[i]);
            weiCount = weiCount + flagCount'(remWei[i] & passMask[i]);
        end
    end

    // A count of CHANNEL_DEPTH truncates to 0
    // which still lands right, the counters wrap at the same size
    assign step = '{
        valid:     scanEn & pairsLeft,
        offsetAct: chAddr'(actCount),
        offsetWei: chAddr'(weiCount)
    };

    // Every granted step passes at least one flag in each mask
    stepPassesFlags: assert property (@(posedge clk) disable iff (!rst_n)
        step.valid |-> (actCount != '0) && (weiCount != '0));

endmodule

/* design/pairAddrCounter.sv */
// ======================================
// Compressed address counters
// Activation address, weight offset and
// the strobe that marks a fresh pair
// ======================================

module pairAddrCounter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  sparseCtrlPkg::scanStep step,
    output sparseDataPkg::chAddr   actAddr,
    output sparseDataPkg::chAddr   weiOffset,
    output logic                   addrValid
);
    import sparseDataPkg::*;

    // ======================================
    // Address counters
    // ======================================
    // Preset to all-ones so the first offset of 1 gives index 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            actAddr   <= '1;
            weiOffset <= '1;
        end else if (start) begin
            actAddr   <= '1;
            weiOffset <= '1;
        end else if (step.valid) begin
            // Skip the zeros packed out of each vector
            actAddr   <= actAddr + step.offsetAct;
            weiOffset <= weiOffset + step.offsetWei;
        end
    end

    // ======================================
    // Pair strobe
    // ======================================
    // One cycle behind the step, aligned with the new addresses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addrValid <= 1'b0;
        end else if (start) begin
            // Restart flushes a pending pair
            addrValid <= 1'b0;
        end else begin
            addrValid <= step.valid;
        end
    end

endmodule

/* design/macControl.sv */
// ======================================
// MAC control FSM
// IDLE/COMP sequencing, scan enable and
// the done pulse after the last product
// ======================================

module macControl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic pairsLeft,
    input  logic addrValid,
    output logic scanEn,
    output logic done
);
    import sparseCtrlPkg::*;

    macState state;

    // ======================================
    // State register
    // ======================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= COMP;
                    end
                end
                COMP: begin
                    // A start here restarts the job in place
                    if (done && !start) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ======================================
    // Outputs
    // ======================================
    // Scanner may grant steps for the whole COMP stay
    assign scanEn = (state == COMP);

    // Nothing left to scan and the last pair has drained
    // into the accumulator, so psumOut is final this cycle
    assign done = scanEn && !pairsLeft && !addrValid;

    // Single-cycle done unless a new job follows at once
    doneIsPulse: assert property (@(posedge clk) disable iff (!rst_n)
        done && !start |=> !done);

endmodule

/* design/macAccumulator.sv */
// ======================================
// MAC datapath
// Operand selection from the compressed
// vectors, multiply and wrapping sum
// ======================================
`include "sparseMac_params.svh"

module macAccumulator (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  sparseDataPkg::accWord    psumIn,
    input  sparseDataPkg::macOperands operands,
    input  sparseDataPkg::chAddr     actAddr,
    input  sparseDataPkg::chAddr     weiOffset,
    input  logic                     addrValid,
    output sparseDataPkg::accWord    psumOut
);
    import sparseDataPkg::*;

    weiAddr weiIdx;
    actWord actSel;
    weiWord weiSel;
    accWord product;

    // ======================================
    // Operand select
    // ======================================
    // Weights start at the job's base slot
    assign weiIdx = operands.weiBase + weiAddr'(weiOffset);
    assign actSel = operands.actVec[actAddr];
    assign weiSel = operands.weiBlk[weiIdx];

    // Unsigned multiply, upper bits drop at ACC_WIDTH
    assign product = accWord'(actSel) * accWord'(weiSel);

    // ======================================
    // Accumulator
    // ======================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psumOut <= '0;
        end else if (start) begin
            // Seed with the upstream partial sum
            psumOut <= psumIn;
        end else if (addrValid) begin
            // Wraps modulo 2**ACC_WIDTH
            psumOut <= psumOut + product;
        end
    end

    // Base plus packed weight count must stay inside the block
    weiIdxInBlock: assert property (@(posedge clk) disable iff (!rst_n)
        addrValid |-> weiIdx < weiAddr'(`WEI_SLOTS));

endmodule

/* design/sparseMacUnit.sv */
// ======================================
// Sparse MAC unit top level
// Flag scanner, address counters,
// control FSM and accumulator
// ======================================

module sparseMacUnit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  sparseDataPkg::flagVec     flagAct,
    input  sparseDataPkg::flagVec     flagWei,
    input  sparseDataPkg::macOperands operands,
    input  sparseDataPkg::accWord     psumIn,
    output logic                      done,
    output sparseDataPkg::accWord     psumOut
);
    import sparseDataPkg::*;
    import sparseCtrlPkg::*;

    // Scan side
    scanStep step;
    logic    pairsLeft;
    logic    scanEn;

    // Address side
    chAddr   actAddr;
    chAddr   weiOffset;
    logic    addrValid;

    // ======================================
    // Instances
    // ======================================
    flagScanner scannerInst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .flagAct   (flagAct),
        .flagWei   (flagWei),
        .scanEn    (scanEn),
        .step      (step),
        .pairsLeft (pairsLeft)
    );

    pairAddrCounter addrInst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .step      (step),
        .actAddr   (actAddr),
        .weiOffset (weiOffset),
        .addrValid (addrValid)
    );

    macControl ctrlInst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .pairsLeft (pairsLeft),
        .addrValid (addrValid),
        .scanEn    (scanEn),
        .done      (done)
    );

    macAccumulator accInst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .psumIn    (psumIn),
        .operands  (operands),
        .actAddr   (actAddr),
        .weiOffset (weiOffset),
        .addrValid (addrValid),
        .psumOut   (psumOut)
    );

endmodule

/* sim/sparseMacTb.sv */
// ======================================
// Testbench for the sparse MAC unit
// Clock, reset, directed and random jobs,
// reference model, compare process and
// watchdog
// ======================================
`include "sparseMac_params.svh"

module sparseMacTb;
    timeunit 1ns;
    timeprecision 100ps;

    import sparseDataPkg::*;

    // Jobs over all tests, sets the watchdog budget
    localparam int numJobs = 55;
    localparam int watchdogCycles = numJobs * (`CHANNEL_DEPTH + 8) + 20;

    logic       clk;
    logic       rst_n;
    logic       start;
    flagVec     flagAct;
    flagVec     flagWei;
    macOperands operands;
    accWord     psumIn;
    logic       done;
    accWord     psumOut;

    integer seed;
    int     errorCount;
    int     jobCount;
    int     testCount;
    int     testJobs;
    int     testErrBase;
    string  testName;

    // Job handed from the driver to the compare process
    bit     checkPending;
    accWord expSum;
    int     holdCycles;

    sparseMacUnit dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .flagAct  (flagAct),
        .flagWei  (flagWei),
        .operands (operands),
        .psumIn   (psumIn),
        .done     (done),
        .psumOut  (psumOut)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    // ======================================
    // Reference model
    // ======================================
    // Walk channels in order, one packed count per mask
    function automatic accWord expectMac(flagVec fa, flagVec fw, macOperands ops,
                                         accWord psum);
        accWord sum;
        chAddr  actCnt;
        weiAddr weiCnt;
        weiAddr weiIdx;
        sum    = '0;
        actCnt = '0;
        weiCnt = '0;
        for (int ch = 0; ch < `CHANNEL_DEPTH; ch++) begin
            if (fa[ch] && fw[ch]) begin
                weiIdx = ops.weiBase + weiCnt;
                sum = sum + accWord'(ops.actVec[actCnt]) * accWord'(ops.weiBlk[weiIdx]);
            end
            if (fa[ch]) begin
                actCnt = actCnt + chAddr'(1);
            end
            if (fw[ch]) begin
                weiCnt = weiCnt + weiAddr'(1);
            end
        end
        return sum + psum;
    endfunction

    // Random activations and weights, caller picks the base
    function automatic macOperands randomOperands(weiAddr base);
        macOperands ops;
        logic [159:0] raw;
        ops.actVec = {$random(seed), $random(seed), $random(seed), $random(seed)};
        raw = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
        ops.weiBlk  = raw[`WEI_SLOTS*`DATA_WIDTH-1:0];
        ops.weiBase = base;
        return ops;
    endfunction

    // ======================================
    // Compare tasks
    // ======================================
    task automatic checkSum(string name, accWord got, accWord exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errorCount++;
        end
    endtask

    // ======================================
    // Job driver and test bookkeeping
    // ======================================
    task automatic runJob(flagVec fa, flagVec fw, macOperands ops, accWord psum, int hold);
        @(posedge clk);
        #1;
        start    = 1'b1;
        flagAct  = fa;
        flagWei  = fw;
        operands = ops;
        psumIn   = psum;
        expSum     = expectMac(fa, fw, ops, psum);
        holdCycles = hold;
        @(posedge clk);
        #1;
        start = 1'b0;
        jobCount++;
        testJobs++;
        // Operands stay put until the compare process is through
        checkPending = 1'b1;
        wait (!checkPending);
    endtask

    task automatic beginTest(string name);
        testName    = name;
        testJobs    = 0;
        testErrBase = errorCount;
        testCount++;
    endtask

    task automatic endTest();
        $display("Test %s: %0d jobs, %0d errors", testName, testJobs,
                 errorCount - testErrBase);
    endtask

    // ======================================
    // Compare process
    // ======================================
    // Samples on the falling edge, away from the drive and update edges
    initial begin : compareProc
        int waited;
        bit seen;
        forever begin
            wait (checkPending);
            waited = 0;
            seen   = 1'b0;
            while (!seen && waited < `CHANNEL_DEPTH + 4) begin
                @(negedge clk);
                waited++;
                seen = done;
            end
            if (!seen) begin
                $display("Error: done never arrived within %0d cycles of start", waited);
                errorCount++;
            end else begin
                checkSum("psumOut", psumOut, expSum);
                // Result must stay put after done
                for (int i = 0; i < holdCycles; i++) begin
                    @(negedge clk);
                    checkSum("psumOut", psumOut, expSum);
                    checkFlag("done", done, 1'b0);
                end
            end
            checkPending = 1'b0;
        end
    end

    // Hard limit on the whole run
    initial begin : watchdog
        #(watchdogCycles * 10);
        $display("Error: watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    // ======================================
    // Stimulus
    // ======================================
    initial begin : mainProc
        macOperands ops;
        flagVec     fa;
        flagVec     fw;
        accWord     psum;
        int         pick;
        seed         = 32'h8d1b2738;
        errorCount   = 0;
        jobCount     = 0;
        testCount    = 0;
        checkPending = 1'b0;
        clk      = 1'b0;
        rst_n    = 1'b0;
        start    = 1'b0;
        flagAct  = '0;
        flagWei  = '0;
        operands = '0;
        psumIn   = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // No flags at all, sum passes straight through
        beginTest("allClear");
        ops = randomOperands(weiAddr'(0));
        runJob('0, '0, ops, accWord'($random(seed)), 0);
        endTest();

        // No shared channel, nonzero data never reaches the sum
        beginTest("disjoint");
        ops.actVec  = {16{8'h3c}};
        ops.weiBlk  = {18{8'hc3}};
        ops.weiBase = weiAddr'(0);
        runJob(flagVec'(16'h00ff), flagVec'(16'hff00), ops, accWord'($random(seed)), 0);
        endTest();

        // Dense dot product, then the weight window moved by 2
        beginTest("dense");
        ops = randomOperands(weiAddr'(0));
        runJob('1, '1, ops, accWord'($random(seed)), 0);
        ops.weiBase = weiAddr'(2);
        runJob('1, '1, ops, accWord'($random(seed)), 0);
        endTest();

        // Sparse jobs, base kept so the weight window fits the block
        beginTest("random");
        for (int j = 0; j < 50; j++) begin
            fa   = flagVec'($random(seed));
            fw   = flagVec'($random(seed));
            pick = $unsigned($random(seed)) % (`WEI_SLOTS - $countones(fw) + 1);
            ops  = randomOperands(weiAddr'(pick));
            psum = accWord'($random(seed));
            runJob(fa, fw, ops, psum, 0);
        end
        endTest();

        // Full-scale operands wrap the sum, result held after done
        beginTest("wrapHold");
        ops.actVec  = '1;
        ops.weiBlk  = '1;
        ops.weiBase = weiAddr'(0);
        psum = '1;
        psum = psum - accWord'(5);
        runJob('1, '1, ops, psum, 3);
        endTest();

        $display("Tests: %0d, jobs: %0d, errors: %0d", testCount, jobCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sparseMacUnit.f */
+incdir+design
design/sparseDataPkg.sv
design/sparseCtrlPkg.sv
design/flagScanner.sv
design/pairAddrCounter.sv
design/macControl.sv
design/macAccumulator.sv
design/sparseMacUnit.sv
sim/sparseMacTb.sv

/* runSim.sh */
#!/bin/sh
# Build the sparse MAC testbench with Verilator and run it
# The verdict comes from the simulation log

rm -rf obj_dir &&
verilator --binary --timing --assert \
    -f sparseMacUnit.f --top-module sparseMacTb \
    --Mdir obj_dir -o sparseMacSim > build.log 2>&1 &&
./obj_dir/sparseMacSim > sim.log 2>&1 ||
{ echo "Build or run error, see build.log and sim.log"; exit 1; }

cat sim.log &&
grep -q "^Simulation passed$" sim.log &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
